// ==== sv32_dmmu.f ====
+incdir+.
sv32_mmu_pkg.sv
sv32_tlb_if.sv
sv32_dtlb.sv
sv32_ld_st_xlate.sv
sv32_dmmu.sv
tb_sv32_dmmu.sv

// ==== Makefile ====
# Verilator build and run of the Sv32 data MMU testbench
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_sv32_dmmu
RTL_TOP    := sv32_dmmu
FILELIST   := sv32_dmmu.f
OBJ_DIR    := obj_dir
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_sv32_dmmu.sv ====
//------------------------------------------------
// self-checking testbench of the Sv32 data MMU
// plays the page table walker through the refill
// port, checks both stages against a TLB model
//------------------------------------------------
`default_nettype none

`include "sv32_mmu_cfg.svh"

module tb_sv32_dmmu;
    import sv32_mmu_pkg::*;

    localparam int N = `SV32_TLB_ENTRIES;

    // DUT inputs
    logic      clk_i;
    logic      rst_ni;
    logic      en_ld_st_translation_i;
    logic      lsu_req_i;
    logic      lsu_is_store_i;
    logic      misaligned_i;
    logic      sum_i;
    logic      flush_tlb_i;
    logic      update_valid_i;
    logic      update_is_4m_i;
    vaddr_t    lsu_vaddr_i;
    vaddr_t    vaddr_to_be_flushed_i;
    priv_lvl_t ld_st_priv_lvl_i;
    asid_t     asid_i;
    asid_t     asid_to_be_flushed_i;
    asid_t     update_asid_i;
    vpn_t      update_vpn_i;
    pte_t      update_pte_i;
    // DUT outputs
    logic      lsu_dtlb_hit_o;
    logic      lsu_valid_o;
    logic      lsu_ex_valid_o;
    logic      dtlb_miss_o;
    ppn_t      lsu_dtlb_ppn_o;
    paddr_t    lsu_paddr_o;
    cause_t    lsu_ex_cause_o;
    vaddr_t    lsu_ex_tval_o;

    // model TLB mirror
    vpn_t      m_vpn   [N];
    asid_t     m_asid  [N];
    logic      m_4m    [N];
    pte_t      m_pte   [N];
    logic      m_valid [N];
    int        m_rr;

    // one-deep queue of the expected second stage
    logic      p_valid;
    logic      p_ex;
    logic      p_chk_pa;
    cause_t    p_cause;
    vaddr_t    p_tval;
    paddr_t    p_paddr;

    // mode applied at each drive point
    logic      cur_en;
    logic      cur_sum;
    priv_lvl_t cur_priv;
    asid_t     cur_asid;
    int        n_err;

    sv32_dmmu i_sv32_dmmu (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    //------------------------------------------------
    // failure reporting and compare tasks
    //------------------------------------------------
    task automatic stop_run(string why);
        n_err++;
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            stop_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_ppn(string name, ppn_t got, ppn_t exp);
        if (got !== exp)
            stop_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_paddr(string name, paddr_t got, paddr_t exp);
        if (got !== exp)
            stop_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_cause(string name, cause_t got, cause_t exp);
        if (got !== exp)
            stop_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_vaddr(string name, vaddr_t got, vaddr_t exp);
        if (got !== exp)
            stop_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // polls the clock, gives up if no rising edge shows
    task automatic wait_rise();
        int n;
        n = 0;
        while (clk_i !== 1'b0 && n < 1000) begin
            #1;
            n++;
        end
        while (clk_i !== 1'b1 && n < 1000) begin
            #1;
            n++;
        end
        if (n >= 1000) stop_run("clock rising edge not seen within 1000 time units");
    endtask

    //------------------------------------------------
    // reference model
    //------------------------------------------------
    function automatic logic page_match(int i, vpn_t vpn);
        return (m_vpn[i][19:10] == vpn[19:10]) && (m_4m[i] || (m_vpn[i][9:0] == vpn[9:0]));
    endfunction

    // lowest hitting index, -1 on a miss
    function automatic int model_find(vpn_t vpn, asid_t asid);
        for (int i = 0; i < N; i++) begin
            if (m_valid[i] && (m_asid[i] == asid) && page_match(i, vpn)) return i;
        end
        return -1;
    endfunction

    function automatic void model_refill(vpn_t vpn, asid_t asid, logic is_4m, pte_t pte);
        int idx;
        idx = -1;
        for (int i = N - 1; i >= 0; i--) begin
            if (m_valid[i] && (m_vpn[i] == vpn) && (m_asid[i] == asid)) idx = i;
        end
        // no tag match, take the round-robin slot
        if (idx < 0) begin
            idx  = m_rr;
            m_rr = (m_rr + 1) % N;
        end
        m_vpn[idx]   = vpn;
        m_asid[idx]  = asid;
        m_4m[idx]    = is_4m;
        m_pte[idx]   = pte;
        m_valid[idx] = 1'b1;
    endfunction

    function automatic void model_flush(asid_t asid, vaddr_t va);
        logic sel;
        for (int i = 0; i < N; i++) begin
            if (asid == '0 && va == '0) begin
                sel = 1'b1;
            end else if (asid == '0) begin
                sel = page_match(i, va[31:12]);
            end else if (va == '0) begin
                sel = (m_asid[i] == asid);
            end else begin
                sel = (m_asid[i] == asid) && page_match(i, va[31:12]);
            end
            if (sel) m_valid[i] = 1'b0;
        end
    endfunction

    function automatic logic priv_error(pte_t pte);
        return ((cur_priv == `SV32_PRIV_S) && !cur_sum && pte[`SV32_PTE_U])
            || ((cur_priv == `SV32_PRIV_U) && !pte[`SV32_PTE_U]);
    endfunction

    function automatic vpn_t page_vpn(int k);
        return {10'(k + 1), 10'(k * 7 + 3)};
    endfunction

    //------------------------------------------------
    // cycle tasks
    //------------------------------------------------
    // checks the previous request's second stage, then drives the mode
    task automatic start_cycle();
        wait_rise();
        #5;
        check_bit("lsu_valid_o", lsu_valid_o, p_valid);
        check_bit("lsu_ex_valid_o", lsu_ex_valid_o, p_ex);
        if (p_ex) begin
            check_cause("lsu_ex_cause_o", lsu_ex_cause_o, p_cause);
            check_vaddr("lsu_ex_tval_o", lsu_ex_tval_o, p_tval);
        end
        if (p_chk_pa) check_paddr("lsu_paddr_o", lsu_paddr_o, p_paddr);
        #5;
        en_ld_st_translation_i = cur_en;
        ld_st_priv_lvl_i       = cur_priv;
        sum_i                  = cur_sum;
        asid_i                 = cur_asid;
        lsu_req_i              = 1'b0;
        misaligned_i           = 1'b0;
        flush_tlb_i            = 1'b0;
        update_valid_i         = 1'b0;
    endtask

    // same-cycle checks, queues the second stage, updates the model
    task automatic end_cycle();
        int   idx;
        ppn_t ppn;
        #10;
        idx = model_find(lsu_vaddr_i[31:12], asid_i);
        check_bit("dtlb_miss_o", dtlb_miss_o, cur_en && lsu_req_i && (idx < 0));
        p_valid  = 1'b0;
        p_ex     = 1'b0;
        p_chk_pa = 1'b0;
        p_cause  = '0;
        p_tval   = lsu_vaddr_i;
        if (lsu_req_i) begin
            ppn = {2'b00, lsu_vaddr_i[31:12]};
            if (cur_en && idx >= 0) begin
                ppn = m_pte[idx][31:10];
                if (m_4m[idx]) ppn[9:0] = lsu_vaddr_i[21:12];
            end
            check_bit("lsu_dtlb_hit_o", lsu_dtlb_hit_o, !cur_en || (idx >= 0));
            if (!cur_en || idx >= 0) check_ppn("lsu_dtlb_ppn_o", lsu_dtlb_ppn_o, ppn);
            p_paddr = {ppn, lsu_vaddr_i[11:0]};
            if (misaligned_i) begin
                p_valid = 1'b1;
                p_ex    = 1'b1;
                p_cause = lsu_is_store_i ? `SV32_CAUSE_ST_MISALIGN : `SV32_CAUSE_LD_MISALIGN;
            end else if (!cur_en || idx >= 0) begin
                p_valid  = 1'b1;
                p_chk_pa = 1'b1;
                if (cur_en && lsu_is_store_i) begin
                    p_ex    = priv_error(m_pte[idx]) || !m_pte[idx][`SV32_PTE_W]
                              || !m_pte[idx][`SV32_PTE_D];
                    p_cause = `SV32_CAUSE_ST_PAGE_FAULT;
                end else if (cur_en) begin
                    p_ex    = priv_error(m_pte[idx]);
                    p_cause = `SV32_CAUSE_LD_PAGE_FAULT;
                end
            end
        end
        // flush wins over a refill in the same cycle
        if (flush_tlb_i) begin
            model_flush(asid_to_be_flushed_i, vaddr_to_be_flushed_i);
        end else if (update_valid_i) begin
            model_refill(update_vpn_i, update_asid_i, update_is_4m_i, update_pte_i);
        end
    endtask

    task automatic access(logic is_store, logic misal, vaddr_t va);
        start_cycle();
        lsu_req_i      = 1'b1;
        lsu_is_store_i = is_store;
        misaligned_i   = misal;
        lsu_vaddr_i    = va;
        end_cycle();
    endtask

    task automatic refill(vpn_t vpn, asid_t asid, logic is_4m, pte_t pte);
        start_cycle();
        update_valid_i = 1'b1;
        update_vpn_i   = vpn;
        update_asid_i  = asid;
        update_is_4m_i = is_4m;
        update_pte_i   = pte;
        end_cycle();
    endtask

    task automatic flush(asid_t asid, vaddr_t va);
        start_cycle();
        flush_tlb_i           = 1'b1;
        asid_to_be_flushed_i  = asid;
        vaddr_to_be_flushed_i = va;
        end_cycle();
    endtask

    // entry set for the flush tests, page 0 shared by both ASIDs
    task automatic fill_flush_set();
        for (int j = 0; j < 4; j++) begin
            refill(page_vpn(j == 3 ? 0 : j), asid_t'(j < 2 ? 1 : 2), 1'b0, pte_t'($urandom));
        end
    endtask

    task automatic probe_flush_set();
        for (int j = 0; j < 4; j++) begin
            cur_asid = asid_t'(j < 2 ? 1 : 2);
            access(1'b0, 1'b0, {page_vpn(j == 3 ? 0 : j), 12'($urandom)});
        end
    endtask

    //------------------------------------------------
    // stimulus
    //------------------------------------------------
    initial begin : main
        vpn_t        vpn;
        int          k;
        int unsigned seed;
        seed = 32'hc23c_631d;
        void'($urandom(seed));
        n_err = 0;
        m_rr  = 0;
        for (int i = 0; i < N; i++) m_valid[i] = 1'b0;
        p_valid  = 1'b0;
        p_ex     = 1'b0;
        p_chk_pa = 1'b0;
        cur_en   = 1'b0;
        cur_sum  = 1'b0;
        cur_priv = `SV32_PRIV_S;
        cur_asid = '0;
        rst_ni                 = 1'b0;
        en_ld_st_translation_i = 1'b0;
        lsu_req_i              = 1'b0;
        lsu_is_store_i         = 1'b0;
        misaligned_i           = 1'b0;
        sum_i                  = 1'b0;
        flush_tlb_i            = 1'b0;
        update_valid_i         = 1'b0;
        update_is_4m_i         = 1'b0;
        lsu_vaddr_i            = '0;
        vaddr_to_be_flushed_i  = '0;
        ld_st_priv_lvl_i       = `SV32_PRIV_S;
        asid_i                 = '0;
        asid_to_be_flushed_i   = '0;
        update_asid_i          = '0;
        update_vpn_i           = '0;
        update_pte_i           = '0;
        repeat (16) wait_rise();
        #10;
        rst_ni = 1'b1;

        // bare mode, physical equals virtual
        repeat (40) begin
            cur_priv = priv_lvl_t'($urandom_range(0, 1));
            cur_sum  = 1'($urandom);
            access(1'($urandom), 1'b0, $urandom);
        end

        // 4K pages, two more than fit, the first two get evicted
        cur_en   = 1'b1;
        cur_asid = asid_t'(3);
        cur_priv = `SV32_PRIV_S;
        cur_sum  = 1'b1;
        for (int i = 0; i < N + 2; i++) begin
            refill(page_vpn(i), cur_asid, 1'b0, pte_t'($urandom));
            access(1'b0, 1'b0, {page_vpn(i), 12'($urandom)});
        end
        // same tag again, rewritten in place
        refill(page_vpn(N + 1), cur_asid, 1'b0, pte_t'($urandom));
        for (int i = 0; i < N + 2; i++) begin
            access(1'($urandom), 1'b0, {page_vpn(i), 12'($urandom)});
        end

        // megapages, vpn[0] passes through
        flush('0, '0);
        for (int i = 0; i < N; i++) begin
            vpn = {10'(10'h200 + i), 10'($urandom)};
            refill(vpn, cur_asid, 1'b1, pte_t'($urandom));
            repeat (3) access(1'($urandom), 1'b0, {vpn[19:10], 22'($urandom)});
        end

        // random flags, privilege and SUM
        flush('0, '0);
        for (int i = 0; i < N; i++) refill(page_vpn(i), cur_asid, 1'b0, pte_t'($urandom));
        repeat (60) begin
            k = $urandom_range(0, N - 1);
            refill(page_vpn(k), cur_asid, 1'b0, pte_t'($urandom));
            cur_priv = priv_lvl_t'($urandom_range(0, 1));
            cur_sum  = 1'($urandom);
            access(1'($urandom), 1'b0, {page_vpn(k), 12'($urandom)});
        end

        // misses in an unmapped region, misaligned on any page
        repeat (20) begin
            access(1'($urandom), 1'($urandom), {10'h3ff, 22'($urandom)});
            access(1'($urandom), 1'b1, {page_vpn($urandom_range(0, N - 1)), 12'($urandom)});
        end
        cur_en = 1'b0;
        access(1'b1, 1'b1, $urandom);
        cur_en = 1'b1;

        // flush by address, by ASID, by both, then everything
        flush('0, '0);
        fill_flush_set();
        flush('0, {page_vpn(0), 12'h000});
        probe_flush_set();
        flush('0, '0);
        fill_flush_set();
        flush(asid_t'(2), '0);
        probe_flush_set();
        flush('0, '0);
        fill_flush_set();
        // page 0 lives under both ASIDs, only the ASID 2 copy goes
        flush(asid_t'(2), {page_vpn(0), 12'h000});
        probe_flush_set();
        flush('0, '0);
        probe_flush_set();

        // drain the last second stage
        start_cycle();
        end_cycle();
        if (n_err == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sv32_dmmu.sv ====
//------------------------------------------------
// data-side Sv32 MMU, top level
// connects the data TLB and the load-store
// translation stage, refills come from outside
//------------------------------------------------
`default_nettype none

module sv32_dmmu (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       en_ld_st_translation_i,
    // load-store unit
    input  logic                       lsu_req_i,
    input  sv32_mmu_pkg::vaddr_t       lsu_vaddr_i,
    input  logic                       lsu_is_store_i,
    input  logic                       misaligned_i,
    output logic                       lsu_dtlb_hit_o,
    output sv32_mmu_pkg::ppn_t         lsu_dtlb_ppn_o,
    output logic                       lsu_valid_o,
    output sv32_mmu_pkg::paddr_t       lsu_paddr_o,
    output logic                       lsu_ex_valid_o,
    output sv32_mmu_pkg::cause_t       lsu_ex_cause_o,
    output sv32_mmu_pkg::vaddr_t       lsu_ex_tval_o,
    // privilege and address space
    input  sv32_mmu_pkg::priv_lvl_t    ld_st_priv_lvl_i,
    input  logic                       sum_i,
    input  sv32_mmu_pkg::asid_t        asid_i,
    // TLB maintenance
    input  logic                       flush_tlb_i,
    input  sv32_mmu_pkg::asid_t        asid_to_be_flushed_i,
    input  sv32_mmu_pkg::vaddr_t       vaddr_to_be_flushed_i,
    input  logic                       update_valid_i,
    input  sv32_mmu_pkg::vpn_t         update_vpn_i,
    input  sv32_mmu_pkg::asid_t        update_asid_i,
    input  logic                       update_is_4m_i,
    input  sv32_mmu_pkg::pte_t         update_pte_i,
    // performance counter
    output logic                       dtlb_miss_o
);

    // raw miss from the TLB, not yet qualified by the enable
    logic tlb_miss;

    sv32_tlb_if i_lu_if ();

    sv32_dtlb i_dtlb (
        .clk_i          ( clk_i                 ),
        .rst_ni         ( rst_ni                ),
        .flush_i        ( flush_tlb_i           ),
        .flush_asid_i   ( asid_to_be_flushed_i  ),
        .flush_vaddr_i  ( vaddr_to_be_flushed_i ),
        .lu_asid_i      ( asid_i                ),
        .update_valid_i ( update_valid_i        ),
        .update_vpn_i   ( update_vpn_i          ),
        .update_asid_i  ( update_asid_i         ),
        .update_is_4m_i ( update_is_4m_i        ),
        .update_pte_i   ( update_pte_i          ),
        .lu             ( i_lu_if.tlb_mp        ),
        .miss_o         ( tlb_miss              )
    );

    sv32_ld_st_xlate i_ld_st_xlate (
        .clk_i                  ( clk_i                  ),
        .rst_ni                 ( rst_ni                 ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .lsu_req_i              ( lsu_req_i              ),
        .lsu_is_store_i         ( lsu_is_store_i         ),
        .misaligned_i           ( misaligned_i           ),
        .sum_i                  ( sum_i                  ),
        .lsu_vaddr_i            ( lsu_vaddr_i            ),
        .ld_st_priv_lvl_i       ( ld_st_priv_lvl_i       ),
        .tlb_miss_i             ( tlb_miss               ),
        .lu                     ( i_lu_if.xlate_mp       ),
        .lsu_dtlb_hit_o         ( lsu_dtlb_hit_o         ),
        .lsu_dtlb_ppn_o         ( lsu_dtlb_ppn_o         ),
        .lsu_valid_o            ( lsu_valid_o            ),
        .lsu_ex_valid_o         ( lsu_ex_valid_o         ),
        .lsu_paddr_o            ( lsu_paddr_o            ),
        .lsu_ex_cause_o         ( lsu_ex_cause_o         ),
        .lsu_ex_tval_o          ( lsu_ex_tval_o          ),
        .dtlb_miss_o            ( dtlb_miss_o            )
    );

endmodule

`default_nettype wire

// ==== sv32_ld_st_xlate.sv ====
//------------------------------------------------
// load-store address translation
// cycle 0 gives hit and ppn from the TLB lookup,
// cycle 1 gives paddr, valid and one exception
//------------------------------------------------
`default_nettype none

`include "sv32_mmu_cfg.svh"

module sv32_ld_st_xlate (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       en_ld_st_translation_i,
    input  logic                       lsu_req_i,
    input  logic                       lsu_is_store_i,
    input  logic                       misaligned_i,
    input  logic                       sum_i,
    input  sv32_mmu_pkg::vaddr_t       lsu_vaddr_i,
    input  sv32_mmu_pkg::priv_lvl_t    ld_st_priv_lvl_i,
    input  logic                       tlb_miss_i,
    sv32_tlb_if.xlate_mp               lu,
    output logic                       lsu_dtlb_hit_o,
    output sv32_mmu_pkg::ppn_t         lsu_dtlb_ppn_o,
    output logic                       lsu_valid_o,
    output logic                       lsu_ex_valid_o,
    output sv32_mmu_pkg::paddr_t       lsu_paddr_o,
    output sv32_mmu_pkg::cause_t       lsu_ex_cause_o,
    output sv32_mmu_pkg::vaddr_t       lsu_ex_tval_o,
    output logic                       dtlb_miss_o
);
    import sv32_mmu_pkg::*;

    // stage 1 state
    logic   req_q;
    logic   misaligned_q;
    logic   hit_q;
    logic   is_store_q;
    logic   is_4m_q;
    vaddr_t vaddr_q;
    pte_t   pte_q;

    ppn_t   ppn_q;
    logic   priv_err;

    //------------------------------------------------
    // cycle 0
    //------------------------------------------------
    assign lu.access = lsu_req_i;
    assign lu.vaddr  = lsu_vaddr_i;

    // bare mode always hits
    assign lsu_dtlb_hit_o = en_ld_st_translation_i ? lu.hit : 1'b1;
    assign dtlb_miss_o    = en_ld_st_translation_i && tlb_miss_i;

    always_comb begin : ppn_now
        lsu_dtlb_ppn_o = {2'b00, lsu_vaddr_i[31:12]};
        if (en_ld_st_translation_i) begin
            lsu_dtlb_ppn_o = lu.pte[31:10];
            // megapage, vpn[0] passes through
            if (lu.is_4m) begin
                lsu_dtlb_ppn_o[9:0] = lsu_vaddr_i[21:12];
            end
        end
    end

    //------------------------------------------------
    // cycle 1
    //------------------------------------------------
    assign ppn_q = is_4m_q ? {pte_q[31:20], vaddr_q[21:12]} : pte_q[31:10];

    // S without SUM on a user page, or U on a supervisor page
    assign priv_err = ((ld_st_priv_lvl_i == `SV32_PRIV_S) && !sum_i && pte_q[`SV32_PTE_U])
                   || ((ld_st_priv_lvl_i == `SV32_PRIV_U) && !pte_q[`SV32_PTE_U]);

    always_comb begin : result
        lsu_paddr_o    = {2'b00, vaddr_q};
        lsu_valid_o    = req_q;
        lsu_ex_valid_o = 1'b0;
        lsu_ex_cause_o = '0;
        lsu_ex_tval_o  = '0;
        // misaligned goes first, TLB state ignored
        if (misaligned_q) begin
            lsu_valid_o    = 1'b1;
            lsu_ex_valid_o = 1'b1;
            lsu_ex_cause_o = is_store_q ? `SV32_CAUSE_ST_MISALIGN : `SV32_CAUSE_LD_MISALIGN;
            lsu_ex_tval_o  = vaddr_q;
        end else if (en_ld_st_translation_i) begin
            lsu_valid_o = 1'b0;
            lsu_paddr_o = {ppn_q, vaddr_q[11:0]};
            if (req_q && hit_q) begin
                lsu_valid_o = 1'b1;
                if (is_store_q) begin
                    // store needs W and D set on top of the privilege check
                    if (priv_err || !pte_q[`SV32_PTE_W] || !pte_q[`SV32_PTE_D]) begin
                        lsu_ex_valid_o = 1'b1;
                        lsu_ex_cause_o = `SV32_CAUSE_ST_PAGE_FAULT;
                        lsu_ex_tval_o  = vaddr_q;
                    end
                end else if (priv_err) begin
                    lsu_ex_valid_o = 1'b1;
                    lsu_ex_cause_o = `SV32_CAUSE_LD_PAGE_FAULT;
                    lsu_ex_tval_o  = vaddr_q;
                end
            end
        end
    end

    //------------------------------------------------
    // registers
    //------------------------------------------------
    // misaligned flag only counts with a request
    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            req_q        <= 1'b0;
            misaligned_q <= 1'b0;
            hit_q        <= 1'b0;
        end else begin
            req_q        <= lsu_req_i;
            misaligned_q <= misaligned_i && lsu_req_i;
            hit_q        <= lu.hit;
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        is_4m_q    <= lu.is_4m;
        pte_q      <= lu.pte;
    end

    // an exception belongs to a request from the cycle before
    a_ex_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_ex_valid_o |-> (lsu_valid_o && $past(lsu_req_i)));

    // a TLB miss never turns into a valid translation
    a_miss_invalid : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (en_ld_st_translation_i && lsu_req_i && !lu.hit && !misaligned_i)
        |=> (!en_ld_st_translation_i || !lsu_valid_o));

endmodule

`default_nettype wire

// ==== sv32_dtlb.sv ====
//------------------------------------------------
// fully associative data TLB, 4 KiB and 4 MiB pages
// combinational lookup, refill from the update port
// with round-robin replacement, flush by ASID/address
//------------------------------------------------
`default_nettype none

`include "sv32_mmu_cfg.svh"

module sv32_dtlb (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  sv32_mmu_pkg::asid_t   flush_asid_i,
    input  sv32_mmu_pkg::vaddr_t  flush_vaddr_i,
    input  sv32_mmu_pkg::asid_t   lu_asid_i,
    input  logic                  update_valid_i,
    input  sv32_mmu_pkg::vpn_t    update_vpn_i,
    input  sv32_mmu_pkg::asid_t   update_asid_i,
    input  logic                  update_is_4m_i,
    input  sv32_mmu_pkg::pte_t    update_pte_i,
    sv32_tlb_if.tlb_mp            lu,
    output logic                  miss_o
);
    import sv32_mmu_pkg::*;

    localparam int unsigned N     = `SV32_TLB_ENTRIES;
    localparam int unsigned IDX_W = (N > 1) ? $clog2(N) : 1;

    // entry storage
    vpn_t             tag_vpn_q  [N];
    asid_t            tag_asid_q [N];
    logic             tag_4m_q   [N];
    pte_t             pte_q      [N];
    logic [N-1:0]     valid_q;
    logic [IDX_W-1:0] rr_ptr_q;

    logic [N-1:0]     hit_vec;
    logic [N-1:0]     flush_vec;
    logic [IDX_W-1:0] upd_idx;
    logic [IDX_W-1:0] rr_next;
    logic             upd_hit;
    logic             flush_asid_zero;
    logic             flush_addr_zero;

    // vpn[1] always compared, vpn[0] only for 4K entries
    function automatic logic vpn_match(vpn_t tag, vpn_t vpn, logic is_4m);
        return (tag[19:10] == vpn[19:10]) && (is_4m || (tag[9:0] == vpn[9:0]));
    endfunction

    //------------------------------------------------
    // lookup
    //------------------------------------------------
    always_comb begin : lookup
        for (int i = 0; i < N; i++) begin
            hit_vec[i] = valid_q[i] && (tag_asid_q[i] == lu_asid_i)
                         && vpn_match(tag_vpn_q[i], lu.vaddr[31:12], tag_4m_q[i]);
        end
    end

    // walk downwards so the lowest hitting index wins
    always_comb begin : select
        lu.hit   = 1'b0;
        lu.pte   = '0;
        lu.is_4m = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                lu.hit   = 1'b1;
                lu.pte   = pte_q[i];
                lu.is_4m = tag_4m_q[i];
            end
        end
    end

    // perf counter strobe, the enable is applied downstream
    assign miss_o = lu.access && !lu.hit;

    //------------------------------------------------
    // refill target and flush selection
    //------------------------------------------------
    // an existing entry with the same tag is rewritten in place
    always_comb begin : refill_idx
        upd_hit = 1'b0;
        upd_idx = rr_ptr_q;
        for (int i = N - 1; i >= 0; i--) begin
            if (valid_q[i] && (tag_vpn_q[i] == update_vpn_i)
                && (tag_asid_q[i] == update_asid_i)) begin
                upd_hit = 1'b1;
                upd_idx = IDX_W'(i);
            end
        end
    end

    assign rr_next = (rr_ptr_q == IDX_W'(N - 1)) ? '0 : rr_ptr_q + 1'b1;

    assign flush_asid_zero = (flush_asid_i == '0);
    assign flush_addr_zero = (flush_vaddr_i == '0);

    // zero fields act as wildcards
    always_comb begin : flush_sel
        for (int i = 0; i < N; i++) begin
            if (flush_asid_zero && flush_addr_zero) begin
                flush_vec[i] = 1'b1;
            end else if (flush_asid_zero) begin
                flush_vec[i] = vpn_match(tag_vpn_q[i], flush_vaddr_i[31:12], tag_4m_q[i]);
            end else if (flush_addr_zero) begin
                flush_vec[i] = (tag_asid_q[i] == flush_asid_i);
            end else begin
                flush_vec[i] = (tag_asid_q[i] == flush_asid_i)
                               && vpn_match(tag_vpn_q[i], flush_vaddr_i[31:12], tag_4m_q[i]);
            end
        end
    end

    //------------------------------------------------
    // registers
    //------------------------------------------------
    // flush wins over a refill in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush_i) begin
            valid_q <= valid_q & ~flush_vec;
        end else if (update_valid_i) begin
            valid_q[upd_idx] <= 1'b1;
            if (!upd_hit) begin
                rr_ptr_q <= rr_next;
            end
        end
    end

    always_ff @(posedge clk_i) begin : entry_regs
        if (update_valid_i && !flush_i) begin
            tag_vpn_q[upd_idx]  <= update_vpn_i;
            tag_asid_q[upd_idx] <= update_asid_i;
            tag_4m_q[upd_idx]   <= update_is_4m_i;
            pte_q[upd_idx]      <= update_pte_i;
        end
    end

    // refills never create overlapping entries
    a_one_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
        lu.access |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== sv32_tlb_if.sv ====
//------------------------------------------------
// one combinational lookup into the data TLB
// the translation stage asks, the TLB answers in
// the same cycle
//------------------------------------------------
`default_nettype none

interface sv32_tlb_if;
    import sv32_mmu_pkg::*;

    // request side
    logic   access;
    vaddr_t vaddr;

    // answer side
    logic   hit;
    pte_t   pte;
    logic   is_4m;

    // TLB end of the lookup
    modport tlb_mp (
        input  access, vaddr,
        output hit, pte, is_4m
    );

    // load-store translation end
    modport xlate_mp (
        output access, vaddr,
        input  hit, pte, is_4m
    );

endinterface

`default_nettype wire

// ==== sv32_mmu_pkg.sv ====
//------------------------------------------------
// vector types of the Sv32 data MMU
// shared by the RTL and the testbench, compile first
//------------------------------------------------
`default_nettype none

`include "sv32_mmu_cfg.svh"

package sv32_mmu_pkg;

    // addresses and page numbers
    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    typedef logic [19:0] vpn_t;
    typedef logic [21:0] ppn_t;

    // leaf PTE, ppn in 31:10, flags below
    typedef logic [31:0] pte_t;

    // address space identifier
    typedef logic [`SV32_ASID_W-1:0] asid_t;

    // privilege level and exception cause
    typedef logic [1:0] priv_lvl_t;
    typedef logic [3:0] cause_t;

endpackage

`default_nettype wire

// ==== sv32_mmu_cfg.svh ====
//------------------------------------------------
// build-time constants of the Sv32 data MMU
// include wherever entry count, ASID width, PTE
// flag positions, privilege or cause codes are used
//------------------------------------------------
`ifndef SV32_MMU_CFG_SVH
`define SV32_MMU_CFG_SVH

// data TLB geometry
`define SV32_TLB_ENTRIES 4
`define SV32_ASID_W 4

// leaf PTE flag bit positions
`define SV32_PTE_W 2
`define SV32_PTE_U 4
`define SV32_PTE_D 7

// privilege levels seen by loads and stores
`define SV32_PRIV_U 2'd0
`define SV32_PRIV_S 2'd1

// exception causes raised by the data path
`define SV32_CAUSE_LD_MISALIGN 4'd4
`define SV32_CAUSE_ST_MISALIGN 4'd6
`define SV32_CAUSE_LD_PAGE_FAULT 4'd13
`define SV32_CAUSE_ST_PAGE_FAULT 4'd15

`endif
